// ==== source/revo_link_pkg.sv ====
`default_nettype none

package revo_link_pkg;

	// revo sample history, newest sample in bit 0
	localparam int window_width = 16;

	// oldest samples that must be quiet ahead of a pulse
	localparam int quiet_length = 8;

	// longest pulse still accepted, in clock254 cycles
	localparam int max_pulse_width = 7;

	// flops between the asynchronous revo input and the window
	localparam int sync_stages = 2;

	// calibration word geometry
	localparam int cal_word_width = 8;

	// selected while word_select is high
	localparam logic [cal_word_width-1:0] cal_word_a = 8'hf4;

	// selected while word_select is low
	localparam logic [cal_word_width-1:0] cal_word_b = 8'hf2;

	// marker encoder in the output stage
	typedef enum logic [1:0] {
		// trg_out follows the forwarded clock
		mark_idle,
		// marker pending, waiting for a low phase
		mark_wait_phase,
		// trg_out out of step for one clock127 period
		mark_hold
	} mark_state_e;

endpackage

`default_nettype wire

// ==== source/revo_pulse_qualifier.sv ====
`default_nettype none

module revo_pulse_qualifier (
	input  logic clock254,
	input  logic rst_n,
	input  logic revo_in,
	output logic revo_strobe
);
	import revo_link_pkg::*;

	logic [sync_stages-1:0]  revo_sync;
	logic [window_width-1:0] window;
	logic                    quiet_before;
	logic                    pulse_seen;
	logic                    pulse_ended;

	// revo_in has no relation to clock254
	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			revo_sync <= '0;
		end else begin
			revo_sync <= {revo_sync[sync_stages-2:0], revo_in};
		end
	end

	// sample history, oldest sample at the top
	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			window <= '0;
		end else begin
			window <= {window[window_width-2:0], revo_sync[sync_stages-1]};
		end
	end

	// upper half all zero
	assign quiet_before = (window[window_width-1 -: quiet_length] == '0);

	// leading edge has just reached the oldest lower-half slot
	assign pulse_seen = window[window_width-quiet_length-1];

	// sample max_pulse_width+1 after the leading edge is low again,
	// so anything wider than max_pulse_width is dropped here
	assign pulse_ended = !window[window_width-quiet_length-1-max_pulse_width];

	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			revo_strobe <= 1'b0;
		end else begin
			revo_strobe <= quiet_before && pulse_seen && pulse_ended;
		end
	end

	// a single leading edge can only line up with the pattern once
	strobe_single_cycle: assert property (
		@(posedge clock254) disable iff (!rst_n)
		revo_strobe |=> !revo_strobe
	) else $error("revo_strobe high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== source/calibration_serializer.sv ====
`default_nettype none

module calibration_serializer (
	input  logic clock254,
	input  logic rst_n,
	input  logic word_select,
	output logic ser_bit,
	output logic ser_word_start
);
	import revo_link_pkg::*;

	logic [$clog2(cal_word_width)-1:0] bit_count;
	logic [cal_word_width-1:0]         shift_word;
	logic                              word_wrap;

	// last bit of the current word
	assign word_wrap = (bit_count == cal_word_width - 1);

	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			bit_count <= '0;
		end else if (word_wrap) begin
			bit_count <= '0;
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// word_select only matters at the boundary, so no word is ever mixed
	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			shift_word <= '0;
		end else if (word_wrap) begin
			if (word_select) begin
				shift_word <= cal_word_a;
			end else begin
				shift_word <= cal_word_b;
			end
		end else begin
			shift_word <= {shift_word[cal_word_width-2:0], 1'b0};
		end
	end

	// high while the msb of a fresh word is on ser_bit
	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			ser_word_start <= 1'b0;
		end else begin
			ser_word_start <= word_wrap;
		end
	end

	// msb first
	assign ser_bit = shift_word[cal_word_width-1];

	word_start_period: assert property (
		@(posedge clock254) disable iff (!rst_n)
		ser_word_start |=>
			(!ser_word_start) [*(cal_word_width - 1)] ##1 ser_word_start
	) else $error("ser_word_start period is not cal_word_width cycles");

endmodule

`default_nettype wire

// ==== source/link_output_stage.sv ====
`default_nettype none

module link_output_stage (
	input  logic clock254,
	input  logic rst_n,
	input  logic revo_strobe,
	input  logic ser_bit,
	input  logic ser_word_start,
	output logic clock127_out,
	output logic trg_out,
	output logic revo_marker,
	output logic cal_data,
	output logic cal_word_start
);
	import revo_link_pkg::*;

	mark_state_e state;
	mark_state_e state_next;
	logic        phase;

	// half-rate forwarded clock
	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			phase <= 1'b0;
		end else begin
			phase <= ~phase;
		end
	end

	assign clock127_out = phase;

	// strobes seen outside idle join the mark already underway
	always_comb begin
		state_next = state;
		case (state)
			mark_idle: begin
				if (revo_strobe) begin
					state_next = mark_wait_phase;
				end
			end
			mark_wait_phase: begin
				if (!phase) begin
					state_next = mark_hold;
				end
			end
			mark_hold: begin
				// phase is high on the first hold cycle, low on the second
				if (!phase) begin
					state_next = mark_idle;
				end
			end
			default: begin
				state_next = mark_idle;
			end
		endcase
	end

	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			state <= mark_idle;
		end else begin
			state <= state_next;
		end
	end

	// trg_out misses one toggle entering the hold and one leaving it,
	// which leaves it inverted against clock127_out for a full period
	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			trg_out <= 1'b0;
		end else if ((state_next == mark_hold) != (state == mark_hold)) begin
			trg_out <= trg_out;
		end else begin
			trg_out <= ~trg_out;
		end
	end

	// marker and calibration lane, one cycle behind their sources
	always_ff @(posedge clock254 or negedge rst_n) begin
		if (!rst_n) begin
			revo_marker    <= 1'b0;
			cal_data       <= 1'b0;
			cal_word_start <= 1'b0;
		end else begin
			revo_marker    <= revo_strobe;
			cal_data       <= ser_bit;
			cal_word_start <= ser_word_start;
		end
	end

	trg_only_in_hold: assert property (
		@(posedge clock254) disable iff (!rst_n)
		(trg_out != clock127_out) |-> (state == mark_hold)
	) else $error("trg_out departs from clock127_out outside mark_hold");

	hold_two_cycles: assert property (
		@(posedge clock254) disable iff (!rst_n)
		$rose(state == mark_hold) |=> (state == mark_hold) ##1 (state != mark_hold)
	) else $error("mark_hold did not last exactly two cycles");

endmodule

`default_nettype wire

// ==== source/revo_link_top.sv ====
`default_nettype none

module revo_link_top (
	input  logic clock254,
	input  logic rst_n,
	input  logic revo_in,
	input  logic word_select,
	output logic clock127_out,
	output logic trg_out,
	output logic revo_marker,
	output logic cal_data,
	output logic cal_word_start
);

	// qualifier to output stage
	logic revo_strobe;

	// serializer to output stage
	logic ser_bit;
	logic ser_word_start;

	revo_pulse_qualifier i_revo_pulse_qualifier (
		.clock254    (clock254),
		.rst_n       (rst_n),
		.revo_in     (revo_in),
		.revo_strobe (revo_strobe)
	);

	calibration_serializer i_calibration_serializer (
		.clock254       (clock254),
		.rst_n          (rst_n),
		.word_select    (word_select),
		.ser_bit        (ser_bit),
		.ser_word_start (ser_word_start)
	);

	link_output_stage i_link_output_stage (
		.clock254       (clock254),
		.rst_n          (rst_n),
		.revo_strobe    (revo_strobe),
		.ser_bit        (ser_bit),
		.ser_word_start (ser_word_start),
		.clock127_out   (clock127_out),
		.trg_out        (trg_out),
		.revo_marker    (revo_marker),
		.cal_data       (cal_data),
		.cal_word_start (cal_word_start)
	);

endmodule

`default_nettype wire

// ==== tests/revo_link_tb.sv ====
`default_nettype none

module revo_link_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import revo_link_pkg::*;

	typedef struct packed {
		int   width;
		int   gap;
		logic sel;
		int   markers;
	} row_t;

	localparam int num_rows = 12;
	localparam int marker_latency = 12;
	localparam int tail_cycles = 40;
	localparam int max_random_gap = 30;

	logic clock254;
	logic rst_n;
	logic revo_in;
	logic word_select;
	logic clock127_out;
	logic trg_out;
	logic revo_marker;
	logic cal_data;
	logic cal_word_start;

	row_t rows [num_rows];
	int   row_count = 0;
	int   cyc = 0;
	int   error_count = 0;
	int   check_count = 0;
	int   words_checked = 0;
	logic armed = 1'b0;
	int   expected_marks [$];
	int   seen_marks [$];

	// monitor state
	logic                      have_prev = 1'b0;
	logic                      prev_clock127;
	logic                      ws_d1 = 1'b0;
	logic                      ws_d2 = 1'b0;
	logic [2:0]                xor_bits;
	int                        since_marker = 3;
	logic                      mark_phase;
	int                        cap_left = 0;
	logic [cal_word_width-1:0] cap_word;
	logic                      cap_sel;
	int                        last_word_start = -1;

	revo_link_top i_revo_link_top (
		.clock254       (clock254),
		.rst_n          (rst_n),
		.revo_in        (revo_in),
		.word_select    (word_select),
		.clock127_out   (clock127_out),
		.trg_out        (trg_out),
		.revo_marker    (revo_marker),
		.cal_data       (cal_data),
		.cal_word_start (cal_word_start)
	);

	initial begin
		clock254 = 1'b0;
		forever #20 clock254 = ~clock254;
	end

	// edge count, the time base for marker latency
	always @(posedge clock254) begin
		cyc <= cyc + 1;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			$display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic add_row(input int width, input int gap, input logic sel, input int markers);
		rows[row_count].width = width;
		rows[row_count].gap = gap;
		rows[row_count].sel = sel;
		rows[row_count].markers = markers;
		row_count++;
	endtask

	// gap 0 means a random quiet gap
	task automatic load_table();
		add_row(1, 0, 1'b1, 1);
		add_row(3, 0, 1'b0, 1);
		add_row(7, 0, 1'b1, 1);
		add_row(8, 0, 1'b0, 0);
		add_row(12, 0, 1'b1, 0);
		add_row(2, 0, 1'b0, 1);
		// next row follows after only 6 quiet cycles and is rejected
		add_row(3, 0, 1'b1, 1);
		add_row(2, 6, 1'b0, 0);
		add_row(5, 0, 1'b1, 1);
		add_row(7, 0, 1'b0, 1);
		add_row(1, 0, 1'b1, 1);
		add_row(9, 0, 1'b0, 0);
	endtask

	function automatic int table_cycles();
		int total;
		total = 3 + tail_cycles;
		for (int i = 0; i < num_rows; i++) begin
			total += (rows[i].gap == 0) ? max_random_gap : rows[i].gap;
			total += rows[i].width;
		end
		return total;
	endfunction

	task automatic step();
		@(posedge clock254);
		#2;
	endtask

	task automatic expect_outputs_low();
		check_value("clock127_out", 0, clock127_out);
		check_value("trg_out", 0, trg_out);
		check_value("revo_marker", 0, revo_marker);
		check_value("cal_data", 0, cal_data);
		check_value("cal_word_start", 0, cal_word_start);
	endtask

	// outputs sampled mid-cycle, away from the rising edge
	always @(negedge clock254) begin
		if (armed) begin
			if (have_prev) begin
				check_value("clock127_out", !prev_clock127, clock127_out);
			end
			prev_clock127 = clock127_out;
			have_prev = 1'b1;

			// marker encoding on trg_out
			if (revo_marker) begin
				seen_marks.push_back(cyc);
				since_marker = 0;
				mark_phase = clock127_out;
				xor_bits = '0;
				check_value("trg_out ^ clock127_out", 0, trg_out ^ clock127_out);
			end else if (since_marker < 3) begin
				since_marker++;
				xor_bits = {xor_bits[1:0], trg_out ^ clock127_out};
				// hold starts once the phase reads low
				if (since_marker == 3) begin
					check_value("trg_out ^ clock127_out window",
						mark_phase ? 3'b011 : 3'b110, xor_bits);
				end
			end else begin
				check_value("trg_out ^ clock127_out", 0, trg_out ^ clock127_out);
			end

			// select level the serializer saw at its wrap edge
			if (cal_word_start) begin
				if (last_word_start >= 0) begin
					check_value("cal_word_start period", cal_word_width,
						cyc - last_word_start);
				end
				last_word_start = cyc;
				cap_left = cal_word_width;
				cap_word = '0;
				cap_sel = ws_d2;
			end
			if (cap_left > 0) begin
				cap_word = {cap_word[cal_word_width-2:0], cal_data};
				cap_left--;
				if (cap_left == 0) begin
					check_value("cal_data word", cap_sel ? cal_word_a : cal_word_b, cap_word);
					words_checked++;
				end
			end
			ws_d2 = ws_d1;
			ws_d1 = word_select;
		end
	end

	initial begin
		int unsigned seed_state;
		int          gap;
		int          start;
		rst_n = 1'b0;
		revo_in = 1'b0;
		word_select = 1'b0;
		seed_state = $urandom(32'haf72_0aab);
		load_table();

		repeat (2) begin
			@(negedge clock254);
			expect_outputs_low();
		end
		@(posedge clock254);
		#2;
		rst_n = 1'b1;
		armed = 1'b1;
		// nothing moves before the first edge after release
		@(negedge clock254);
		expect_outputs_low();
		step();

		for (int i = 0; i < num_rows; i++) begin
			if (rows[i].gap == 0) begin
				gap = 10 + ($urandom % 21);
			end else begin
				gap = rows[i].gap;
			end
			word_select = rows[i].sel;
			repeat (gap) step();
			revo_in = 1'b1;
			start = cyc;
			if (rows[i].markers > 0) begin
				expected_marks.push_back(start + marker_latency);
			end
			repeat (rows[i].width) step();
			revo_in = 1'b0;
		end
		repeat (tail_cycles) step();

		check_value("marker count", expected_marks.size(), seen_marks.size());
		for (int i = 0; i < expected_marks.size() && i < seen_marks.size(); i++) begin
			check_value("revo_marker cycle", expected_marks[i], seen_marks[i]);
		end
		if (words_checked == 0) begin
			$display("no calibration word was captured on cal_data");
			error_count++;
		end

		$display("errors: %0d, checks: %0d, words: %0d", error_count, check_count, words_checked);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// the table is loaded at time zero, before the first edge
	initial begin
		int limit;
		@(posedge clock254);
		limit = table_cycles() + 200;
		repeat (limit) @(posedge clock254);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/revo_link_pkg.sv
source/revo_pulse_qualifier.sv
source/calibration_serializer.sv
source/link_output_stage.sv
source/revo_link_top.sv
tests/revo_link_tb.sv

// ==== Bender.yml ====
package:
  name: revo_link

dependencies: {}

sources:
  # package first, then the blocks, then the top level
  - files:
      - source/revo_link_pkg.sv
      - source/revo_pulse_qualifier.sv
      - source/calibration_serializer.sv
      - source/link_output_stage.sv
      - source/revo_link_top.sv

  - target: test
    files:
      - tests/revo_link_tb.sv
